//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Word and line geometry of the main memory
`define MEM_WORD_BITS 32
`define MEM_LINE_WORDS 16
`define MEM_LINE_BITS 512

// Line address seen from the L2 side
`define MEM_INDEX_BITS 5
`define MEM_TAG_BITS 21

// Stored lines are addressed by the lowest tag bit followed by the index
`define MEM_ADDR_BITS 6
`define MEM_LINES 64

// Access latency in clock cycles, counted down by the latency timer
`define MEM_LATENCY 4
`define MEM_TIMER_BITS 4

`endif

//--- mem_pkg.sv
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

	// A full cache line, word 0 sits in the low bits
	typedef logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_BITS-1:0] mem_line_t;

	// Everything the L2 side presents with a request
	typedef struct packed {
		logic [`MEM_TAG_BITS-1:0] tag;
		logic [`MEM_INDEX_BITS-1:0] index;
		mem_line_t wline;
	} mem_req_t;

	// Operation latched for the store
	typedef enum logic {
		op_read = 1'b0,
		op_write = 1'b1
	} mem_op_t;

	// Controller states
	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_wait = 3'd1,
		st_access = 3'd2,
		st_respond = 3'd3,
		st_hold = 3'd4
	} mem_state_t;

endpackage

`default_nettype wire

//--- mem_latency_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_latency_timer (
	input logic clk,
	input logic rstn,
	input logic start,
	output logic done
);

	logic [`MEM_TIMER_BITS-1:0] count;
	logic last_step;

	// Final decrement, the count goes from one to zero on this edge
	assign last_step = (count == `MEM_TIMER_BITS'(1));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				// A start during a running count simply reloads it
				count <= `MEM_TIMER_BITS'(`MEM_LATENCY);
			end else if (count != '0) begin
				count <= count - `MEM_TIMER_BITS'(1);
				done <= last_step;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_line_store (
	input logic clk,
	input logic rstn,
	input logic strobe,
	input mem_pkg::mem_op_t op,
	input logic [`MEM_ADDR_BITS-1:0] addr,
	input mem_pkg::mem_line_t wline,
	output mem_pkg::mem_line_t rline
);

	import mem_pkg::*;

	logic do_write;
	logic do_read;

	// Flat line storage so the array maps onto block RAM
	logic [`MEM_LINE_BITS-1:0] mem_array [0:`MEM_LINES-1];

	initial begin
		$readmemh("mem_image.hex", mem_array);
	end

	assign do_write = strobe && (op == op_write);
	assign do_read = strobe && (op == op_read);

	// Write port
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem_array[addr] <= wline;
		end
	end

	// The read register keeps its line until the next read
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rline <= '0;
		end else if (do_read) begin
			rline <= mem_line_t'(mem_array[addr]);
		end
	end

endmodule

`default_nettype wire

//--- mem_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_ctrl_fsm (
	input logic clk,
	input logic rstn,
	input logic read_req,
	input logic write_req,
	input mem_pkg::mem_req_t req,
	output logic timer_start,
	input logic timer_done,
	output logic strobe,
	output mem_pkg::mem_op_t op,
	output logic [`MEM_ADDR_BITS-1:0] addr,
	output mem_pkg::mem_line_t wline,
	output logic ready
);

	import mem_pkg::*;

	mem_state_t state;
	mem_state_t state_next;

	logic read_q;
	logic write_q;
	logic read_rise;
	logic write_rise;
	logic any_rise;
	logic any_req;
	logic accept;

	// Previous samples of both request levels
	always_ff @(posedge clk) begin
		if (!rstn) begin
			read_q <= 1'b0;
			write_q <= 1'b0;
		end else begin
			read_q <= read_req;
			write_q <= write_req;
		end
	end

	assign read_rise = read_req && !read_q;
	assign write_rise = write_req && !write_q;
	assign any_rise = read_rise || write_rise;
	assign any_req = read_req || write_req;

	// Rising edges seen while busy are dropped
	assign accept = (state == st_idle) && any_rise;

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (any_rise) begin
					state_next = st_wait;
				end
			end
			st_wait: begin
				if (timer_done) begin
					state_next = st_access;
				end
			end
			st_access: begin
				state_next = st_respond;
			end
			st_respond: begin
				state_next = st_hold;
			end
			st_hold: begin
				// Stay here until the L2 side has let go of its request
				if (!any_req) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// Request payload, captured on the accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			op <= read_rise ? op_read : op_write;
			addr <= {req.tag[0], req.index};
			wline <= req.wline;
		end
	end

	assign timer_start = accept;
	assign strobe = (state == st_access);
	assign ready = (state == st_respond);

endmodule

`default_nettype wire

//--- mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_top (
	input logic clk,
	input logic rstn,
	input logic read_req,
	input logic write_req,
	input mem_pkg::mem_req_t req,
	output logic ready,
	output mem_pkg::mem_line_t read_data
);

	import mem_pkg::*;

	logic timer_start;
	logic timer_done;
	logic strobe;
	mem_op_t op;
	logic [`MEM_ADDR_BITS-1:0] addr;
	mem_line_t wline;

	// Upper tag bits arrive with the request but select nothing here
	mem_ctrl_fsm u_ctrl (
		.clk(clk),
		.rstn(rstn),
		.read_req(read_req),
		.write_req(write_req),
		.req(req),
		.timer_start(timer_start),
		.timer_done(timer_done),
		.strobe(strobe),
		.op(op),
		.addr(addr),
		.wline(wline),
		.ready(ready)
	);

	mem_latency_timer u_timer (
		.clk(clk),
		.rstn(rstn),
		.start(timer_start),
		.done(timer_done)
	);

	mem_line_store u_store (
		.clk(clk),
		.rstn(rstn),
		.strobe(strobe),
		.op(op),
		.addr(addr),
		.wline(wline),
		.rline(read_data)
	);

endmodule

`default_nettype wire

//--- tb_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_top;

	import mem_pkg::*;

	localparam int CLK_HALF_NS = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_WRITES = 16;
	localparam int HOLD_CYCLES = 20;
	localparam int READY_EDGE = `MEM_LATENCY + 2;
	// Every line read once, a write and a read per write, one held read, the read and write pair
	localparam int NUM_REQUESTS = `MEM_LINES + 2 * NUM_WRITES + 3;
	localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (`MEM_LATENCY + 8) + RESET_CYCLES;

	logic clk;
	logic rstn;
	logic read_req;
	logic write_req;
	mem_req_t req;
	logic ready;
	mem_line_t read_data;

	logic [31:0] lfsr_state = 32'haccf_1bae;
	mem_line_t shadow [0:`MEM_LINES-1];
	mem_line_t expect_q [$];
	mem_line_t last_read;
	int checked = 0;

	mem_top u_dut (
		.clk(clk),
		.rstn(rstn),
		.read_req(read_req),
		.write_req(write_req),
		.req(req),
		.ready(ready),
		.read_data(read_data)
	);

	always #(CLK_HALF_NS) clk = ~clk;

	function automatic mem_line_t image_line(input int a);
		mem_line_t line;
		for (int w = 0; w < `MEM_LINE_WORDS; w++) begin
			line[w] = {8'hab, 8'(a), 8'h5c, 8'(w)};
		end
		return line;
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// One LFSR step for every bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic mem_req_t random_req(input logic [`MEM_ADDR_BITS-1:0] a);
		mem_req_t r;
		r.tag = `MEM_TAG_BITS'({take_bits(`MEM_TAG_BITS - 1), a[`MEM_ADDR_BITS-1]});
		r.index = a[`MEM_INDEX_BITS-1:0];
		for (int w = 0; w < `MEM_LINE_WORDS; w++) begin
			r.wline[w] = take_bits(`MEM_WORD_BITS);
		end
		return r;
	endfunction

	task automatic stop_on_error();
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_line(input mem_line_t got, input mem_line_t exp);
		if (got !== exp) begin
			$display("Error at time %0t: read_data %h, expected %h", $time, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at time %0t: ready %b, expected %b, %s", $time, got, exp, what);
			stop_on_error();
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			$display("Error at time %0t: ready after %0d edges, expected %0d", $time, got, exp);
			stop_on_error();
		end
	endtask

	// Called on a falling edge, holds the request past ready for hold cycles
	task automatic run_request(input logic rd, input logic wr, input mem_req_t r, input int hold);
		int edge_count;
		edge_count = -1;
		req = r;
		read_req = rd;
		write_req = wr;
		do begin
			@(negedge clk);
			edge_count++;
			if (edge_count > READY_EDGE) begin
				check_ready(ready, 1'b1, "no ready after the access latency");
			end
		end while (!ready);
		check_latency(edge_count, READY_EDGE);
		repeat (hold) begin
			@(negedge clk);
			check_ready(ready, 1'b0, "second ready while the request is held");
		end
		read_req = 1'b0;
		write_req = 1'b0;
		@(negedge clk);
		check_ready(ready, 1'b0, "ready longer than one cycle");
		@(negedge clk);
	endtask

	task automatic read_line(input logic [`MEM_ADDR_BITS-1:0] a, input int hold);
		last_read = shadow[a];
		expect_q.push_back(last_read);
		run_request(1'b1, 1'b0, random_req(a), hold);
	endtask

	task automatic write_line(input logic [`MEM_ADDR_BITS-1:0] a);
		mem_req_t r;
		r = random_req(a);
		shadow[a] = r.wline;
		// A write leaves the read register alone
		expect_q.push_back(last_read);
		run_request(1'b0, 1'b1, r, 0);
	endtask

	// Responses are compared where ready is seen, on the falling edge
	always @(negedge clk) begin
		if (rstn && ready) begin
			if (expect_q.size() == 0) begin
				$display("Error at time %0t: ready with no request outstanding", $time);
				stop_on_error();
			end else begin
				check_line(read_data, expect_q.pop_front());
				checked++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_HALF_NS * 2);
		$display("The run took longer than the requests allow and was stopped");
		$display("Test failures found");
		$fatal(1, "Watchdog timeout");
	end

	initial begin
		logic [`MEM_ADDR_BITS-1:0] a;
		clk = 1'b0;
		rstn = 1'b0;
		read_req = 1'b0;
		write_req = 1'b0;
		req = '0;
		last_read = '0;
		for (int i = 0; i < `MEM_LINES; i++) begin
			shadow[i] = image_line(i);
		end
		repeat (RESET_CYCLES) @(negedge clk);
		check_ready(ready, 1'b0, "during reset");
		check_line(read_data, '0);
		rstn = 1'b1;
		@(negedge clk);
		for (int i = 0; i < `MEM_LINES; i++) begin
			read_line(`MEM_ADDR_BITS'(i), 0);
		end
		repeat (NUM_WRITES) begin
			a = `MEM_ADDR_BITS'(take_bits(`MEM_ADDR_BITS));
			write_line(a);
			read_line(a, 0);
		end
		read_line(`MEM_ADDR_BITS'(take_bits(`MEM_ADDR_BITS)), HOLD_CYCLES);
		// Both requests together, the read wins and the line stays as it was
		a = `MEM_ADDR_BITS'(take_bits(`MEM_ADDR_BITS));
		last_read = shadow[a];
		expect_q.push_back(last_read);
		run_request(1'b1, 1'b1, random_req(a), 0);
		read_line(a, 0);
		if (checked != NUM_REQUESTS || expect_q.size() != 0) begin
			$display("Only %0d of %0d responses arrived", checked, NUM_REQUESTS);
			$display("Test failures found");
			$fatal(1, "Missing responses");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- mem_image.hex
// One 512-bit line per row, word 15 first and word 0 last, row n is line address n
ab005c0fab005c0eab005c0dab005c0cab005c0bab005c0aab005c09ab005c08ab005c07ab005c06ab005c05ab005c04ab005c03ab005c02ab005c01ab005c00
ab015c0fab015c0eab015c0dab015c0cab015c0bab015c0aab015c09ab015c08ab015c07ab015c06ab015c05ab015c04ab015c03ab015c02ab015c01ab015c00
ab025c0fab025c0eab025c0dab025c0cab025c0bab025c0aab025c09ab025c08ab025c07ab025c06ab025c05ab025c04ab025c03ab025c02ab025c01ab025c00
ab035c0fab035c0eab035c0dab035c0cab035c0bab035c0aab035c09ab035c08ab035c07ab035c06ab035c05ab035c04ab035c03ab035c02ab035c01ab035c00
ab045c0fab045c0eab045c0dab045c0cab045c0bab045c0aab045c09ab045c08ab045c07ab045c06ab045c05ab045c04ab045c03ab045c02ab045c01ab045c00
ab055c0fab055c0eab055c0dab055c0cab055c0bab055c0aab055c09ab055c08ab055c07ab055c06ab055c05ab055c04ab055c03ab055c02ab055c01ab055c00
ab065c0fab065c0eab065c0dab065c0cab065c0bab065c0aab065c09ab065c08ab065c07ab065c06ab065c05ab065c04ab065c03ab065c02ab065c01ab065c00
ab075c0fab075c0eab075c0dab075c0cab075c0bab075c0aab075c09ab075c08ab075c07ab075c06ab075c05ab075c04ab075c03ab075c02ab075c01ab075c00
ab085c0fab085c0eab085c0dab085c0cab085c0bab085c0aab085c09ab085c08ab085c07ab085c06ab085c05ab085c04ab085c03ab085c02ab085c01ab085c00
ab095c0fab095c0eab095c0dab095c0cab095c0bab095c0aab095c09ab095c08ab095c07ab095c06ab095c05ab095c04ab095c03ab095c02ab095c01ab095c00
ab0a5c0fab0a5c0eab0a5c0dab0a5c0cab0a5c0bab0a5c0aab0a5c09ab0a5c08ab0a5c07ab0a5c06ab0a5c05ab0a5c04ab0a5c03ab0a5c02ab0a5c01ab0a5c00
ab0b5c0fab0b5c0eab0b5c0dab0b5c0cab0b5c0bab0b5c0aab0b5c09ab0b5c08ab0b5c07ab0b5c06ab0b5c05ab0b5c04ab0b5c03ab0b5c02ab0b5c01ab0b5c00
ab0c5c0fab0c5c0eab0c5c0dab0c5c0cab0c5c0bab0c5c0aab0c5c09ab0c5c08ab0c5c07ab0c5c06ab0c5c05ab0c5c04ab0c5c03ab0c5c02ab0c5c01ab0c5c00
ab0d5c0fab0d5c0eab0d5c0dab0d5c0cab0d5c0bab0d5c0aab0d5c09ab0d5c08ab0d5c07ab0d5c06ab0d5c05ab0d5c04ab0d5c03ab0d5c02ab0d5c01ab0d5c00
ab0e5c0fab0e5c0eab0e5c0dab0e5c0cab0e5c0bab0e5c0aab0e5c09ab0e5c08ab0e5c07ab0e5c06ab0e5c05ab0e5c04ab0e5c03ab0e5c02ab0e5c01ab0e5c00
ab0f5c0fab0f5c0eab0f5c0dab0f5c0cab0f5c0bab0f5c0aab0f5c09ab0f5c08ab0f5c07ab0f5c06ab0f5c05ab0f5c04ab0f5c03ab0f5c02ab0f5c01ab0f5c00
ab105c0fab105c0eab105c0dab105c0cab105c0bab105c0aab105c09ab105c08ab105c07ab105c06ab105c05ab105c04ab105c03ab105c02ab105c01ab105c00
ab115c0fab115c0eab115c0dab115c0cab115c0bab115c0aab115c09ab115c08ab115c07ab115c06ab115c05ab115c04ab115c03ab115c02ab115c01ab115c00
ab125c0fab125c0eab125c0dab125c0cab125c0bab125c0aab125c09ab125c08ab125c07ab125c06ab125c05ab125c04ab125c03ab125c02ab125c01ab125c00
ab135c0fab135c0eab135c0dab135c0cab135c0bab135c0aab135c09ab135c08ab135c07ab135c06ab135c05ab135c04ab135c03ab135c02ab135c01ab135c00
ab145c0fab145c0eab145c0dab145c0cab145c0bab145c0aab145c09ab145c08ab145c07ab145c06ab145c05ab145c04ab145c03ab145c02ab145c01ab145c00
ab155c0fab155c0eab155c0dab155c0cab155c0bab155c0aab155c09ab155c08ab155c07ab155c06ab155c05ab155c04ab155c03ab155c02ab155c01ab155c00
ab165c0fab165c0eab165c0dab165c0cab165c0bab165c0aab165c09ab165c08ab165c07ab165c06ab165c05ab165c04ab165c03ab165c02ab165c01ab165c00
ab175c0fab175c0eab175c0dab175c0cab175c0bab175c0aab175c09ab175c08ab175c07ab175c06ab175c05ab175c04ab175c03ab175c02ab175c01ab175c00
ab185c0fab185c0eab185c0dab185c0cab185c0bab185c0aab185c09ab185c08ab185c07ab185c06ab185c05ab185c04ab185c03ab185c02ab185c01ab185c00
ab195c0fab195c0eab195c0dab195c0cab195c0bab195c0aab195c09ab195c08ab195c07ab195c06ab195c05ab195c04ab195c03ab195c02ab195c01ab195c00
ab1a5c0fab1a5c0eab1a5c0dab1a5c0cab1a5c0bab1a5c0aab1a5c09ab1a5c08ab1a5c07ab1a5c06ab1a5c05ab1a5c04ab1a5c03ab1a5c02ab1a5c01ab1a5c00
ab1b5c0fab1b5c0eab1b5c0dab1b5c0cab1b5c0bab1b5c0aab1b5c09ab1b5c08ab1b5c07ab1b5c06ab1b5c05ab1b5c04ab1b5c03ab1b5c02ab1b5c01ab1b5c00
ab1c5c0fab1c5c0eab1c5c0dab1c5c0cab1c5c0bab1c5c0aab1c5c09ab1c5c08ab1c5c07ab1c5c06ab1c5c05ab1c5c04ab1c5c03ab1c5c02ab1c5c01ab1c5c00
ab1d5c0fab1d5c0eab1d5c0dab1d5c0cab1d5c0bab1d5c0aab1d5c09ab1d5c08ab1d5c07ab1d5c06ab1d5c05ab1d5c04ab1d5c03ab1d5c02ab1d5c01ab1d5c00
ab1e5c0fab1e5c0eab1e5c0dab1e5c0cab1e5c0bab1e5c0aab1e5c09ab1e5c08ab1e5c07ab1e5c06ab1e5c05ab1e5c04ab1e5c03ab1e5c02ab1e5c01ab1e5c00
ab1f5c0fab1f5c0eab1f5c0dab1f5c0cab1f5c0bab1f5c0aab1f5c09ab1f5c08ab1f5c07ab1f5c06ab1f5c05ab1f5c04ab1f5c03ab1f5c02ab1f5c01ab1f5c00
ab205c0fab205c0eab205c0dab205c0cab205c0bab205c0aab205c09ab205c08ab205c07ab205c06ab205c05ab205c04ab205c03ab205c02ab205c01ab205c00
ab215c0fab215c0eab215c0dab215c0cab215c0bab215c0aab215c09ab215c08ab215c07ab215c06ab215c05ab215c04ab215c03ab215c02ab215c01ab215c00
ab225c0fab225c0eab225c0dab225c0cab225c0bab225c0aab225c09ab225c08ab225c07ab225c06ab225c05ab225c04ab225c03ab225c02ab225c01ab225c00
ab235c0fab235c0eab235c0dab235c0cab235c0bab235c0aab235c09ab235c08ab235c07ab235c06ab235c05ab235c04ab235c03ab235c02ab235c01ab235c00
ab245c0fab245c0eab245c0dab245c0cab245c0bab245c0aab245c09ab245c08ab245c07ab245c06ab245c05ab245c04ab245c03ab245c02ab245c01ab245c00
ab255c0fab255c0eab255c0dab255c0cab255c0bab255c0aab255c09ab255c08ab255c07ab255c06ab255c05ab255c04ab255c03ab255c02ab255c01ab255c00
ab265c0fab265c0eab265c0dab265c0cab265c0bab265c0aab265c09ab265c08ab265c07ab265c06ab265c05ab265c04ab265c03ab265c02ab265c01ab265c00
ab275c0fab275c0eab275c0dab275c0cab275c0bab275c0aab275c09ab275c08ab275c07ab275c06ab275c05ab275c04ab275c03ab275c02ab275c01ab275c00
ab285c0fab285c0eab285c0dab285c0cab285c0bab285c0aab285c09ab285c08ab285c07ab285c06ab285c05ab285c04ab285c03ab285c02ab285c01ab285c00
ab295c0fab295c0eab295c0dab295c0cab295c0bab295c0aab295c09ab295c08ab295c07ab295c06ab295c05ab295c04ab295c03ab295c02ab295c01ab295c00
ab2a5c0fab2a5c0eab2a5c0dab2a5c0cab2a5c0bab2a5c0aab2a5c09ab2a5c08ab2a5c07ab2a5c06ab2a5c05ab2a5c04ab2a5c03ab2a5c02ab2a5c01ab2a5c00
ab2b5c0fab2b5c0eab2b5c0dab2b5c0cab2b5c0bab2b5c0aab2b5c09ab2b5c08ab2b5c07ab2b5c06ab2b5c05ab2b5c04ab2b5c03ab2b5c02ab2b5c01ab2b5c00
ab2c5c0fab2c5c0eab2c5c0dab2c5c0cab2c5c0bab2c5c0aab2c5c09ab2c5c08ab2c5c07ab2c5c06ab2c5c05ab2c5c04ab2c5c03ab2c5c02ab2c5c01ab2c5c00
ab2d5c0fab2d5c0eab2d5c0dab2d5c0cab2d5c0bab2d5c0aab2d5c09ab2d5c08ab2d5c07ab2d5c06ab2d5c05ab2d5c04ab2d5c03ab2d5c02ab2d5c01ab2d5c00
ab2e5c0fab2e5c0eab2e5c0dab2e5c0cab2e5c0bab2e5c0aab2e5c09ab2e5c08ab2e5c07ab2e5c06ab2e5c05ab2e5c04ab2e5c03ab2e5c02ab2e5c01ab2e5c00
ab2f5c0fab2f5c0eab2f5c0dab2f5c0cab2f5c0bab2f5c0aab2f5c09ab2f5c08ab2f5c07ab2f5c06ab2f5c05ab2f5c04ab2f5c03ab2f5c02ab2f5c01ab2f5c00
ab305c0fab305c0eab305c0dab305c0cab305c0bab305c0aab305c09ab305c08ab305c07ab305c06ab305c05ab305c04ab305c03ab305c02ab305c01ab305c00
ab315c0fab315c0eab315c0dab315c0cab315c0bab315c0aab315c09ab315c08ab315c07ab315c06ab315c05ab315c04ab315c03ab315c02ab315c01ab315c00
ab325c0fab325c0eab325c0dab325c0cab325c0bab325c0aab325c09ab325c08ab325c07ab325c06ab325c05ab325c04ab325c03ab325c02ab325c01ab325c00
ab335c0fab335c0eab335c0dab335c0cab335c0bab335c0aab335c09ab335c08ab335c07ab335c06ab335c05ab335c04ab335c03ab335c02ab335c01ab335c00
ab345c0fab345c0eab345c0dab345c0cab345c0bab345c0aab345c09ab345c08ab345c07ab345c06ab345c05ab345c04ab345c03ab345c02ab345c01ab345c00
ab355c0fab355c0eab355c0dab355c0cab355c0bab355c0aab355c09ab355c08ab355c07ab355c06ab355c05ab355c04ab355c03ab355c02ab355c01ab355c00
ab365c0fab365c0eab365c0dab365c0cab365c0bab365c0aab365c09ab365c08ab365c07ab365c06ab365c05ab365c04ab365c03ab365c02ab365c01ab365c00
ab375c0fab375c0eab375c0dab375c0cab375c0bab375c0aab375c09ab375c08ab375c07ab375c06ab375c05ab375c04ab375c03ab375c02ab375c01ab375c00
ab385c0fab385c0eab385c0dab385c0cab385c0bab385c0aab385c09ab385c08ab385c07ab385c06ab385c05ab385c04ab385c03ab385c02ab385c01ab385c00
ab395c0fab395c0eab395c0dab395c0cab395c0bab395c0aab395c09ab395c08ab395c07ab395c06ab395c05ab395c04ab395c03ab395c02ab395c01ab395c00
ab3a5c0fab3a5c0eab3a5c0dab3a5c0cab3a5c0bab3a5c0aab3a5c09ab3a5c08ab3a5c07ab3a5c06ab3a5c05ab3a5c04ab3a5c03ab3a5c02ab3a5c01ab3a5c00
ab3b5c0fab3b5c0eab3b5c0dab3b5c0cab3b5c0bab3b5c0aab3b5c09ab3b5c08ab3b5c07ab3b5c06ab3b5c05ab3b5c04ab3b5c03ab3b5c02ab3b5c01ab3b5c00
ab3c5c0fab3c5c0eab3c5c0dab3c5c0cab3c5c0bab3c5c0aab3c5c09ab3c5c08ab3c5c07ab3c5c06ab3c5c05ab3c5c04ab3c5c03ab3c5c02ab3c5c01ab3c5c00
ab3d5c0fab3d5c0eab3d5c0dab3d5c0cab3d5c0bab3d5c0aab3d5c09ab3d5c08ab3d5c07ab3d5c06ab3d5c05ab3d5c04ab3d5c03ab3d5c02ab3d5c01ab3d5c00
ab3e5c0fab3e5c0eab3e5c0dab3e5c0cab3e5c0bab3e5c0aab3e5c09ab3e5c08ab3e5c07ab3e5c06ab3e5c05ab3e5c04ab3e5c03ab3e5c02ab3e5c01ab3e5c00
ab3f5c0fab3f5c0eab3f5c0dab3f5c0cab3f5c0bab3f5c0aab3f5c09ab3f5c08ab3f5c07ab3f5c06ab3f5c05ab3f5c04ab3f5c03ab3f5c02ab3f5c01ab3f5c00

//--- sources.f
+incdir+.
mem_pkg.sv
mem_latency_timer.sv
mem_line_store.sv
mem_ctrl_fsm.sv
mem_top.sv
tb_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass message in sim.log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -f sources.f --top-module tb_mem_top -o tb_mem_top > build.log 2>&1 &&
./obj_dir/tb_mem_top > sim.log 2>&1
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
